// ==== common/bank_ctrl_pkg.sv ====
package bank_ctrl_pkg;

   // ------------------------------
   // Host operations
   // ------------------------------

   // High for a write
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_e;

   // ------------------------------
   // Bank FSM states
   // ------------------------------

   typedef enum logic [1:0] {
      ST_INIT    = 2'd0,  // Start-up delay running
      ST_IDLE    = 2'd1,  // Serving requests
      ST_REFRESH = 2'd2,  // No transfers during refresh
      ST_HOLD    = 2'd3   // Read result waiting for collector
   } bank_state_e;

endpackage

// ==== common/mem_bus_pkg.sv ====
package mem_bus_pkg;

   // ------------------------------
   // Bus widths
   // ------------------------------

   localparam int WIDTH = 32;         // Data word
   localparam int BSELS = WIDTH / 8;  // One select per byte
   localparam int ABITS = 12;         // Host word address

   // ------------------------------
   // Request and response
   // ------------------------------

   // Host request, also what the dispatcher hands to a bank
   typedef struct packed {
      bank_ctrl_pkg::mem_op_e op;
      logic [ABITS-1:0]       address;  // Low bits pick the bank
      logic [BSELS-1:0]       bytes;    // Write byte selects
      logic [WIDTH-1:0]       data;     // Write data
   } mem_req_t;

   // Read result, bank to collector to host
   typedef struct packed {
      logic [WIDTH-1:0] data;
   } mem_rsp_t;

endpackage

// ==== bank/request_dispatch.sv ====
module request_dispatch #(
   parameter  int NBANKS      = 4,
   parameter  int ORDER_DEPTH = 8,
   localparam int BBITS       = (NBANKS > 1) ? $clog2(NBANKS) : 1
) (
   input  logic                  clock_i,
   input  logic                  reset_i,
   input  logic                  request_i,
   input  mem_bus_pkg::mem_req_t req_i,
   input  logic [NBANKS-1:0]     bank_accept_i,
   input  logic                  active_i,
   output logic                  accept_o,
   output logic [NBANKS-1:0]     bank_valid_o,
   output mem_bus_pkg::mem_req_t bank_req_o,
   output logic                  order_push_o,
   output logic [BBITS-1:0]      order_bank_o,
   input  logic                  order_pop_i,
   output logic [BBITS-1:0]      order_head_o,
   output logic                  order_empty_o
);

   localparam int PBITS = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
   localparam int CBITS = $clog2(ORDER_DEPTH + 1);

   logic [BBITS-1:0] bank_sel;
   logic             is_read;
   logic             take;

   logic [BBITS-1:0] order_mem [ORDER_DEPTH];  // Bank index per outstanding read
   logic [PBITS-1:0] wr_ptr;
   logic [PBITS-1:0] rd_ptr;
   logic [CBITS-1:0] count;
   logic             full;

   // ------------------------------
   // Bank decode and accept
   // ------------------------------

   // Low address bits pick the bank, masked so one bank gives index 0
   assign bank_sel = BBITS'(req_i.address) & BBITS'(NBANKS - 1);
   assign is_read  = (req_i.op == bank_ctrl_pkg::OP_READ);

   // Writes never need a queue slot
   assign accept_o = active_i && bank_accept_i[bank_sel] && (!is_read || !full);
   assign take     = request_i && accept_o;  // Host transfer this edge

   always_comb begin
      bank_valid_o           = '0;
      bank_valid_o[bank_sel] = take;  // Only the target bank sees valid
   end

   // Shared request bus, bank drops its own index bits
   assign bank_req_o = req_i;

   // ------------------------------
   // Read order queue
   // ------------------------------

   assign order_push_o  = take && is_read;
   assign order_bank_o  = bank_sel;
   assign order_head_o  = order_mem[rd_ptr];  // Oldest outstanding read
   assign order_empty_o = (count == '0);
   assign full          = (count == CBITS'(ORDER_DEPTH));

   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (order_push_o) begin
            wr_ptr <= (wr_ptr == PBITS'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (order_pop_i) begin
            rd_ptr <= (rd_ptr == PBITS'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Push and pop together leave the count alone
         case ({order_push_o, order_pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Queue storage
   always_ff @(posedge clock_i) begin
      if (order_push_o) begin
         order_mem[wr_ptr] <= order_bank_o;
      end
   end

endmodule

// ==== bank/mem_bank.sv ====
module mem_bank #(
   parameter int NBANKS         = 4,
   parameter int START_CYCLES   = 20,
   parameter int REFRESH_PERIOD = 37,
   parameter int REFRESH_CYCLES = 3
) (
   input  logic                  clock_i,
   input  logic                  reset_i,
   input  logic                  valid_i,
   input  mem_bus_pkg::mem_req_t req_i,
   output logic                  accept_o,
   output logic                  active_o,
   output logic                  rsp_valid_o,
   output mem_bus_pkg::mem_rsp_t rsp_o,
   input  logic                  take_i
);

   localparam int BANK_BITS = $clog2(NBANKS);
   localparam int WORD_BITS = mem_bus_pkg::ABITS - BANK_BITS;
   localparam int DEPTH     = 1 << WORD_BITS;  // Words in this bank
   localparam int IBITS     = (START_CYCLES > 0) ? $clog2(START_CYCLES + 1) : 1;
   localparam int PBITS     = (REFRESH_PERIOD > 1) ? $clog2(REFRESH_PERIOD) : 1;
   localparam int RBITS     = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;

   bank_ctrl_pkg::bank_state_e state;

   logic [IBITS-1:0]           init_cnt;
   logic [PBITS-1:0]           period_cnt;
   logic [RBITS-1:0]           ref_cnt;
   logic                       refresh_pend;  // Period elapsed, refresh not yet run
   logic                       xfer;
   logic                       is_write;
   logic [WORD_BITS-1:0]       word_addr;

   logic [mem_bus_pkg::WIDTH-1:0] mem [DEPTH];

   // Upper address bits only, bank index bits are dropped
   assign word_addr = req_i.address[mem_bus_pkg::ABITS-1 -: WORD_BITS];
   assign is_write  = (req_i.op == bank_ctrl_pkg::OP_WRITE);
   assign xfer      = valid_i && accept_o;

   // A pending refresh blocks new work so IDLE can leave cleanly
   assign accept_o    = (state == bank_ctrl_pkg::ST_IDLE) && !refresh_pend;
   assign active_o    = (state != bank_ctrl_pkg::ST_INIT);
   assign rsp_valid_o = (state == bank_ctrl_pkg::ST_HOLD);

   // ------------------------------
   // Bank FSM
   // ------------------------------

   // INIT leaves on the START_CYCLES+1-th edge with reset low
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         state        <= bank_ctrl_pkg::ST_INIT;
         init_cnt     <= '0;
         period_cnt   <= '0;
         ref_cnt      <= '0;
         refresh_pend <= 1'b0;
      end else begin
         // Refresh timer, runs once start-up is over
         if (state == bank_ctrl_pkg::ST_INIT) begin
            period_cnt <= '0;
         end else if (period_cnt == PBITS'(REFRESH_PERIOD - 1)) begin
            period_cnt <= '0;
         end else begin
            period_cnt <= period_cnt + 1'b1;
         end

         if (state == bank_ctrl_pkg::ST_IDLE && refresh_pend) begin
            refresh_pend <= 1'b0;  // Refresh starts now
         end
         if (state != bank_ctrl_pkg::ST_INIT &&
             period_cnt == PBITS'(REFRESH_PERIOD - 1)) begin
            refresh_pend <= 1'b1;
         end

         unique case (state)
            bank_ctrl_pkg::ST_INIT: begin
               if (init_cnt == IBITS'(START_CYCLES)) begin
                  state <= bank_ctrl_pkg::ST_IDLE;
               end else begin
                  init_cnt <= init_cnt + 1'b1;
               end
            end
            bank_ctrl_pkg::ST_IDLE: begin
               if (refresh_pend) begin
                  state   <= bank_ctrl_pkg::ST_REFRESH;
                  ref_cnt <= '0;
               end else if (xfer && !is_write) begin
                  state <= bank_ctrl_pkg::ST_HOLD;  // Result lands next edge
               end
            end
            bank_ctrl_pkg::ST_REFRESH: begin
               if (ref_cnt == RBITS'(REFRESH_CYCLES - 1)) begin
                  state <= bank_ctrl_pkg::ST_IDLE;
               end else begin
                  ref_cnt <= ref_cnt + 1'b1;
               end
            end
            bank_ctrl_pkg::ST_HOLD: begin
               // Pending refresh waits until the collector has the data
               if (take_i) begin
                  state <= bank_ctrl_pkg::ST_IDLE;
               end
            end
            default: state <= bank_ctrl_pkg::ST_INIT;
         endcase
      end
   end

   // ------------------------------
   // Storage and read register
   // ------------------------------

   always_ff @(posedge clock_i) begin
      if (xfer) begin
         if (is_write) begin
            for (int b = 0; b < mem_bus_pkg::BSELS; b++) begin
               if (req_i.bytes[b]) begin
                  mem[word_addr][b*8 +: 8] <= req_i.data[b*8 +: 8];  // Merge under mask
               end
            end
         end else begin
            rsp_o.data <= mem[word_addr];  // One-cycle read path
         end
      end
   end

endmodule

// ==== bank/response_collect.sv ====
module response_collect #(
   parameter  int NBANKS = 4,
   localparam int BBITS  = (NBANKS > 1) ? $clog2(NBANKS) : 1
) (
   input  logic                              clock_i,
   input  logic                              reset_i,
   input  logic [BBITS-1:0]                  order_head_i,
   input  logic                              order_empty_i,
   output logic                              order_pop_o,
   input  logic [NBANKS-1:0]                 rsp_valid_i,
   input  mem_bus_pkg::mem_rsp_t [NBANKS-1:0] bank_rsp_i,
   output logic [NBANKS-1:0]                 rsp_take_o,
   output logic                              ready_o,
   output mem_bus_pkg::mem_rsp_t             rsp_o
);

   logic head_hit;

   // ------------------------------
   // Head of queue select
   // ------------------------------

   // Only the oldest read may return, later banks keep holding
   assign head_hit    = !order_empty_i && rsp_valid_i[order_head_i];
   assign order_pop_o = head_hit;

   always_comb begin
      rsp_take_o               = '0;
      rsp_take_o[order_head_i] = head_hit;  // Releases the bank back to IDLE
   end

   // ------------------------------
   // Host response register
   // ------------------------------

   // One-cycle pulse per taken response, host never stalls it
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         ready_o <= 1'b0;
      end else begin
         ready_o <= head_hit;
      end
   end

   // Data only meaningful while ready_o is high
   always_ff @(posedge clock_i) begin
      if (head_hit) begin
         rsp_o <= bank_rsp_i[order_head_i];
      end
   end

endmodule

// ==== hdl/mem_subsystem_top.sv ====
module mem_subsystem_top #(
   parameter int NBANKS         = 4,   // Power of two
   parameter int START_CYCLES   = 20,
   parameter int REFRESH_PERIOD = 37,
   parameter int REFRESH_CYCLES = 3,
   parameter int ORDER_DEPTH    = 8    // Outstanding reads
) (
   input  logic                  clock_i,
   input  logic                  reset_i,
   input  logic                  request_i,
   input  mem_bus_pkg::mem_req_t req_i,
   output logic                  accept_o,
   output logic                  active_o,
   output logic                  ready_o,
   output mem_bus_pkg::mem_rsp_t rsp_o
);

   localparam int BBITS = (NBANKS > 1) ? $clog2(NBANKS) : 1;

   logic [NBANKS-1:0]                  bank_valid;
   logic [NBANKS-1:0]                  bank_accept;
   logic [NBANKS-1:0]                  bank_active;
   logic [NBANKS-1:0]                  rsp_valid;
   logic [NBANKS-1:0]                  rsp_take;
   mem_bus_pkg::mem_req_t              bank_req;
   mem_bus_pkg::mem_rsp_t [NBANKS-1:0] bank_rsp;

   logic             order_pop;
   logic             order_empty;
   logic [BBITS-1:0] order_head;

   // Host sees the subsystem up only when all banks are
   assign active_o = &bank_active;

   // ------------------------------
   // Request side
   // ------------------------------

   // Push side of the order queue stays inside the dispatcher
   request_dispatch #(
      .NBANKS      (NBANKS),
      .ORDER_DEPTH (ORDER_DEPTH)
   ) u_dispatch (
      .clock_i       (clock_i),
      .reset_i       (reset_i),
      .request_i     (request_i),
      .req_i         (req_i),
      .bank_accept_i (bank_accept),
      .active_i      (active_o),
      .accept_o      (accept_o),
      .bank_valid_o  (bank_valid),
      .bank_req_o    (bank_req),
      .order_push_o  (),
      .order_bank_o  (),
      .order_pop_i   (order_pop),
      .order_head_o  (order_head),
      .order_empty_o (order_empty)
   );

   // ------------------------------
   // Banks
   // ------------------------------

   for (genvar k = 0; k < NBANKS; k++) begin : g_bank
      mem_bank #(
         .NBANKS         (NBANKS),
         .START_CYCLES   (START_CYCLES),
         .REFRESH_PERIOD (REFRESH_PERIOD),
         .REFRESH_CYCLES (REFRESH_CYCLES)
      ) u_bank (
         .clock_i     (clock_i),
         .reset_i     (reset_i),
         .valid_i     (bank_valid[k]),
         .req_i       (bank_req),
         .accept_o    (bank_accept[k]),
         .active_o    (bank_active[k]),
         .rsp_valid_o (rsp_valid[k]),
         .rsp_o       (bank_rsp[k]),
         .take_i      (rsp_take[k])
      );
   end

   // ------------------------------
   // Response side
   // ------------------------------

   response_collect #(
      .NBANKS (NBANKS)
   ) u_collect (
      .clock_i       (clock_i),
      .reset_i       (reset_i),
      .order_head_i  (order_head),
      .order_empty_i (order_empty),
      .order_pop_o   (order_pop),
      .rsp_valid_i   (rsp_valid),
      .bank_rsp_i    (bank_rsp),
      .rsp_take_o    (rsp_take),
      .ready_o       (ready_o),
      .rsp_o         (rsp_o)
   );

endmodule

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

   // ------------------------------
   // Reference memory
   // ------------------------------

   logic [mem_bus_pkg::WIDTH-1:0] ref_mem [1 << mem_bus_pkg::ABITS];  // Whole host space

   int check_count    = 0;
   int mismatch_count = 0;
   int fail_count     = 0;  // Timeouts, stray pulses, lost reads

   // Byte merge under the select mask
   task automatic ref_write(input mem_bus_pkg::mem_req_t r);
      for (int b = 0; b < mem_bus_pkg::BSELS; b++) begin
         if (r.bytes[b]) begin
            ref_mem[r.address][b*8 +: 8] = r.data[b*8 +: 8];
         end
      end
   endtask

   // Expected read word for one host address
   function automatic mem_bus_pkg::mem_rsp_t ref_read(input logic [mem_bus_pkg::ABITS-1:0] a);
      mem_bus_pkg::mem_rsp_t r;
      r.data = ref_mem[a];
      return r;
   endfunction

   // ------------------------------
   // Compare tasks
   // ------------------------------

   task automatic check_rsp(input mem_bus_pkg::mem_rsp_t got, input mem_bus_pkg::mem_rsp_t exp,
                            input string what);
      check_count++;
      if (got !== exp) begin
         mismatch_count++;
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got.data, exp.data);
      end
   endtask

   task automatic check_active(input logic got, input logic exp, input string what);
      check_count++;
      if (got !== exp) begin
         mismatch_count++;
         $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_cycles(input int got, input int exp, input string what);
      check_count++;
      if (got != exp) begin
         mismatch_count++;
         $display("Mismatch at %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
      end
   endtask

`endif

// ==== tests/tb_mem_subsystem.sv ====
module tb_mem_subsystem;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NBANKS         = 4;
   localparam int START_CYCLES   = 20;
   localparam int REFRESH_PERIOD = 37;
   localparam int REFRESH_CYCLES = 3;
   localparam int ORDER_DEPTH    = 8;
   localparam int RESET_CYCLES   = 8;
   localparam int DRIVE_DELAY    = 10;   // ns after the rising edge
   localparam int WAIT_LIMIT     = 400;  // Cycles per wait loop
   localparam int N_ADDR         = 24;   // Addresses under test
   localparam int N_RAND         = 60;   // Back-to-back random reads

   logic                  clock_i;
   logic                  reset_i;
   logic                  request_i;
   mem_bus_pkg::mem_req_t req_i;
   logic                  accept_o;
   logic                  active_o;
   logic                  ready_o;
   mem_bus_pkg::mem_rsp_t rsp_o;

   int   seed         = 30;
   int   reads_issued = 0;
   int   rsp_count    = 0;
   logic aborted      = 1'b0;  // Set by a timed-out wait

   mem_bus_pkg::mem_rsp_t         exp_q [$];             // Expected data, issue order
   logic [mem_bus_pkg::ABITS-1:0] addr_list [N_ADDR];

   `include "tb_ref_model.svh"

   mem_subsystem_top #(
      .NBANKS         (NBANKS),
      .START_CYCLES   (START_CYCLES),
      .REFRESH_PERIOD (REFRESH_PERIOD),
      .REFRESH_CYCLES (REFRESH_CYCLES),
      .ORDER_DEPTH    (ORDER_DEPTH)
   ) uut (
      .clock_i   (clock_i),
      .reset_i   (reset_i),
      .request_i (request_i),
      .req_i     (req_i),
      .accept_o  (accept_o),
      .active_o  (active_o),
      .ready_o   (ready_o),
      .rsp_o     (rsp_o)
   );

   initial begin
      clock_i = 1'b0;
      forever #50 clock_i = ~clock_i;  // 100 ns period
   end

   // ------------------------------
   // Response compare
   // ------------------------------

   // Negedge sampling, ready_o and rsp_o are registered
   initial begin
      mem_bus_pkg::mem_rsp_t expected;
      forever begin
         @(negedge clock_i);
         if (ready_o === 1'b1) begin
            if (exp_q.size() == 0) begin
               fail_count++;
               $display("Error at %0t ns: ready_o pulsed with no read outstanding", $time);
            end else begin
               expected = exp_q.pop_front();
               check_rsp(rsp_o, expected, $sformatf("read response %0d", rsp_count));
            end
            rsp_count++;
         end
      end
   end

   // ------------------------------
   // Bus and reset tasks
   // ------------------------------

   // Holds reset, checks the idle outputs, releases with the bus quiet
   task automatic apply_reset();
      reset_i = 1'b1;
      repeat (RESET_CYCLES - 1) @(posedge clock_i);
      @(negedge clock_i);
      check_active(active_o, 1'b0, "active_o in reset");
      check_active(accept_o, 1'b0, "accept_o in reset");
      @(posedge clock_i);
      #DRIVE_DELAY;
      request_i = 1'b0;
      reset_i   = 1'b0;
   endtask

   // Edges from reset release until active_o
   task automatic wait_active(output int cycles);
      cycles = 0;
      forever begin
         @(negedge clock_i);
         if (active_o) break;
         if (cycles >= WAIT_LIMIT) begin
            fail_count++;
            aborted = 1'b1;
            $display("Error at %0t ns: active_o never rose after reset", $time);
            return;
         end
         @(posedge clock_i);
         cycles++;
      end
      @(posedge clock_i);
      #DRIVE_DELAY;
   endtask

   task automatic restart(input string what);
      int cycles;
      apply_reset();
      wait_active(cycles);
      if (!aborted) check_cycles(cycles, START_CYCLES + 1, what);
   endtask

   // Leaves request_i high so the next call runs back to back
   task automatic send(input mem_bus_pkg::mem_req_t r);
      int waited;
      waited    = 0;
      request_i = 1'b1;
      req_i     = r;
      forever begin
         @(negedge clock_i);
         if (accept_o) break;  // Taken on the coming edge
         waited++;
         if (waited >= WAIT_LIMIT) begin
            fail_count++;
            aborted   = 1'b1;
            request_i = 1'b0;
            $display("Error at %0t ns: request to %h never accepted", $time, r.address);
            return;
         end
         @(posedge clock_i);
         #DRIVE_DELAY;
      end
      if (r.op == bank_ctrl_pkg::OP_WRITE) begin
         ref_write(r);
      end else begin
         exp_q.push_back(ref_read(r.address));
         reads_issued++;
      end
      @(posedge clock_i);
      #DRIVE_DELAY;
   endtask

   task automatic wait_drain(input string what);
      int waited;
      request_i = 1'b0;  // Bus idle first
      waited    = 0;
      while (exp_q.size() != 0) begin
         if (waited >= WAIT_LIMIT) begin
            fail_count++;
            aborted = 1'b1;
            $display("Error at %0t ns: %0d reads never returned in %s", $time, exp_q.size(), what);
            return;
         end
         @(posedge clock_i);
         waited++;
      end
      @(posedge clock_i);
      #DRIVE_DELAY;
   endtask

   // ------------------------------
   // Test phases
   // ------------------------------

   task automatic write_words(input logic all_bytes);
      mem_bus_pkg::mem_req_t r;
      int rnd;
      for (int i = 0; i < N_ADDR; i++) begin
         rnd       = $random(seed);
         r.op      = bank_ctrl_pkg::OP_WRITE;
         r.address = addr_list[i];
         r.bytes   = all_bytes ? '1 : rnd[mem_bus_pkg::BSELS-1:0];
         r.data    = $random(seed);
         send(r);
         if (aborted) return;
      end
   endtask

   task automatic read_all(input string what);
      mem_bus_pkg::mem_req_t r;
      for (int i = 0; i < N_ADDR; i++) begin
         r         = '0;
         r.op      = bank_ctrl_pkg::OP_READ;
         r.address = addr_list[i];
         send(r);
         if (aborted) return;
      end
      wait_drain(what);
   endtask

   task automatic random_reads();
      mem_bus_pkg::mem_req_t r;
      int base;
      int idx;
      base = rsp_count;
      for (int i = 0; i < N_RAND; i++) begin
         idx       = $unsigned($random(seed)) % N_ADDR;
         r         = '0;
         r.op      = bank_ctrl_pkg::OP_READ;
         r.address = addr_list[idx];
         send(r);
         if (aborted) return;
      end
      wait_drain("random reads");
      if (!aborted && rsp_count - base != N_RAND) begin
         fail_count++;
         $display("Error: %0d of %0d random reads returned", rsp_count - base, N_RAND);
      end
   endtask

   task automatic run_tests();
      logic [31:0] rnd;
      // Low bits cycle through every bank
      for (int i = 0; i < N_ADDR; i++) begin
         rnd          = $random(seed);
         addr_list[i] = (rnd[mem_bus_pkg::ABITS-1:0] & ~mem_bus_pkg::ABITS'(NBANKS - 1))
                        | mem_bus_pkg::ABITS'(i % NBANKS);
      end
      restart("start-up");
      if (aborted) return;
      write_words(1'b1);  // Full words
      if (aborted) return;
      read_all("full-word readback");
      if (aborted) return;
      write_words(1'b0);  // Random byte selects
      if (aborted) return;
      read_all("byte-merge readback");
      if (aborted) return;
      random_reads();
      if (aborted) return;
      // Pending read on the bus while reset hits
      req_i.op      = bank_ctrl_pkg::OP_READ;
      req_i.address = addr_list[0];
      request_i     = 1'b1;
      restart("start-up after mid-run reset");
      if (aborted) return;
      read_all("readback after reset");
   endtask

   task automatic finish_run();
      int errors;
      errors = mismatch_count + fail_count;
      $display("Checks %0d, mismatches %0d, other errors %0d, reads issued %0d, returned %0d",
               check_count, mismatch_count, fail_count, reads_issued, rsp_count);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   initial begin
      reset_i   = 1'b1;
      request_i = 1'b0;
      req_i     = '0;
      @(posedge clock_i);
      #DRIVE_DELAY;
      run_tests();
      finish_run();
   end

endmodule

// ==== files.f ====
+incdir+tests
common/bank_ctrl_pkg.sv
common/mem_bus_pkg.sv
bank/request_dispatch.sv
bank/mem_bank.sv
bank/response_collect.sv
hdl/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
   --timescale 1ns/100ps \
   --top-module tb_mem_subsystem \
   -f files.f \
   -o tb_mem_subsystem

./obj_dir/tb_mem_subsystem | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi

echo "Simulation finished cleanly"
